//--- verilog/regfile_pkg.sv
// register file geometry
// depth, word and index widths, bank split and read port count,
// plus the word, byte lane and write request types
package regfile_pkg;

   localparam int rf_depth       = 1024;                           // total entries
   localparam int rf_addr_w      = $clog2(rf_depth);               // 10 bit register address
   localparam int rf_data_w      = 32;                             // one word
   localparam int rf_bank_count  = 4;
   localparam int rf_bank_addr_w = $clog2(rf_depth / rf_bank_count); // index inside a bank
   localparam int rf_read_ports  = 3;

   typedef logic [rf_addr_w-1:0]   rf_addr_t;
   typedef logic [rf_data_w-1:0]   rf_data_t;
   typedef logic [rf_data_w/8-1:0] rf_byte_en_t; // one bit per byte lane

   // request on the single write port
   typedef struct packed {
      rf_addr_t    addr;
      rf_data_t    data;
      rf_byte_en_t byte_en; // low bit keeps that byte
   } rf_write_t;

endpackage

//--- verilog/wb_pkg.sv
// writeback traffic definitions
// request formats of the ALU and load unit, and the depth of their queues
package wb_pkg;

   localparam int wb_queue_depth = 4; // entries per source queue

   // ALU result, always a full word
   typedef struct packed {
      regfile_pkg::rf_addr_t addr;
      regfile_pkg::rf_data_t data;
   } alu_wb_t;

   // load unit result, byte lanes picked by the access size
   typedef struct packed {
      regfile_pkg::rf_addr_t    addr;
      regfile_pkg::rf_data_t    data;
      regfile_pkg::rf_byte_en_t byte_en;
   } lsu_wb_t;

endpackage

//--- verilog/reg_bank_256x32_3r_1w.sv
// one register bank of 256 words
// three registered read ports and one write port with byte lane enables
`timescale 1ns/1ps

module reg_bank_256x32_3r_1w (
   input  logic                                   clk,
   input  logic [regfile_pkg::rf_bank_addr_w-1:0] rd_addr [regfile_pkg::rf_read_ports],
   output regfile_pkg::rf_data_t                  rd_data [regfile_pkg::rf_read_ports],
   input  logic                                   wr_en,
   input  logic [regfile_pkg::rf_bank_addr_w-1:0] wr_addr,
   input  regfile_pkg::rf_byte_en_t               wr_byte_en,
   input  regfile_pkg::rf_data_t                  wr_data
);

   // storage, contents undefined until written
   regfile_pkg::rf_data_t mem [regfile_pkg::rf_depth / regfile_pkg::rf_bank_count];

   // masked write, one lane per enable bit
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         for (int i = 0; i < $bits(regfile_pkg::rf_byte_en_t); i++)
         begin
            if (wr_byte_en[i])
               mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8]; // untouched lanes hold
         end
      end
   end

   // read data registered, so a colliding write shows up next cycle only
   always_ff @(posedge clk)
   begin
      for (int p = 0; p < regfile_pkg::rf_read_ports; p++)
         rd_data[p] <= mem[rd_addr[p]]; // old word on same-cycle write
   end

endmodule

//--- verilog/reg_file_1024x32_3r_1w.sv
// 1024 x 32 register file built from four 256 entry banks
// write goes to the bank named by the top address bits, each read port
// picks its bank with the bank bits delayed to line up with the data
`timescale 1ns/1ps

module reg_file_1024x32_3r_1w (
   input  logic                   clk,
   input  logic                   rst,
   input  regfile_pkg::rf_addr_t  rd_addr [regfile_pkg::rf_read_ports],
   output regfile_pkg::rf_data_t  rd_data [regfile_pkg::rf_read_ports],
   input  logic                   wr_valid,
   input  regfile_pkg::rf_write_t wr
);

   typedef logic [regfile_pkg::rf_addr_w-regfile_pkg::rf_bank_addr_w-1:0] bank_sel_t;
   typedef logic [regfile_pkg::rf_bank_addr_w-1:0]                        bank_idx_t;

   bank_idx_t             bank_rd_addr [regfile_pkg::rf_read_ports]; // low bits, fanned out
   regfile_pkg::rf_data_t bank_rd_data [regfile_pkg::rf_bank_count][regfile_pkg::rf_read_ports];
   bank_sel_t             rd_bank_q    [regfile_pkg::rf_read_ports]; // bank bits, one cycle late
   bank_sel_t             wr_bank;
   bank_idx_t             wr_idx;
   logic [regfile_pkg::rf_bank_count-1:0] bank_wr_en;

   // split the write address into bank and index
   assign wr_bank = wr.addr[regfile_pkg::rf_addr_w-1:regfile_pkg::rf_bank_addr_w];
   assign wr_idx  = wr.addr[regfile_pkg::rf_bank_addr_w-1:0];

   // one-hot bank enable
   always_comb
   begin
      for (int b = 0; b < regfile_pkg::rf_bank_count; b++)
         bank_wr_en[b] = wr_valid && (wr_bank == bank_sel_t'(b));
   end

   // every bank sees the same index on each read port
   always_comb
   begin
      for (int p = 0; p < regfile_pkg::rf_read_ports; p++)
         bank_rd_addr[p] = rd_addr[p][regfile_pkg::rf_bank_addr_w-1:0];
   end

   // bank bits follow the bank's own read register
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int p = 0; p < regfile_pkg::rf_read_ports; p++)
            rd_bank_q[p] <= '0;
      end
      else
      begin
         for (int p = 0; p < regfile_pkg::rf_read_ports; p++)
            rd_bank_q[p] <= rd_addr[p][regfile_pkg::rf_addr_w-1:regfile_pkg::rf_bank_addr_w];
      end
   end

   // output mux per port, ports are independent
   always_comb
   begin
      for (int p = 0; p < regfile_pkg::rf_read_ports; p++)
         rd_data[p] = bank_rd_data[rd_bank_q[p]][p];
   end

   for (genvar b = 0; b < regfile_pkg::rf_bank_count; b++)
   begin : g_bank
      reg_bank_256x32_3r_1w bank_inst (
         .clk        (clk),
         .rd_addr    (bank_rd_addr),
         .rd_data    (bank_rd_data[b]),
         .wr_en      (bank_wr_en[b]),
         .wr_addr    (wr_idx),          // index goes straight to all banks
         .wr_byte_en (wr.byte_en),
         .wr_data    (wr.data)
      );
   end

endmodule

//--- verilog/wb_queue.sv
// small writeback FIFO for one source
// keeps the order of one source's requests, full and empty are registered
`timescale 1ns/1ps

module wb_queue #(
   parameter type payload_t = wb_pkg::alu_wb_t
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     empty,
   output logic     full
);

   typedef logic [$clog2(wb_pkg::wb_queue_depth)-1:0]   ptr_t;
   typedef logic [$clog2(wb_pkg::wb_queue_depth+1)-1:0] count_t;

   payload_t mem [wb_pkg::wb_queue_depth]; // payload slots, no reset
   ptr_t     wr_ptr;
   ptr_t     rd_ptr;
   count_t   count;
   count_t   count_nxt;
   logic     do_push;
   logic     do_pop;

   // step a pointer, wrapping at the last slot
   function automatic ptr_t ptr_inc(input ptr_t p);
      if (p == ptr_t'(wb_pkg::wb_queue_depth - 1))
         return '0;
      return p + ptr_t'(1);
   endfunction

   assign do_push = push && !full; // push while full is lost
   assign do_pop  = pop && !empty;
   assign head    = mem[rd_ptr];    // oldest entry

   always_comb
   begin
      count_nxt = count;
      if (do_push && !do_pop)
         count_nxt = count + count_t'(1);
      else if (do_pop && !do_push)
         count_nxt = count - count_t'(1);
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         empty  <= 1'b1;
         full   <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_inc(rd_ptr);
         count <= count_nxt;
         empty <= (count_nxt == '0);                                  // flags from next count
         full  <= (count_nxt == count_t'(wb_pkg::wb_queue_depth));
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

endmodule

//--- verilog/wb_arbiter.sv
// round-robin writeback arbiter
// pops at most one of the ALU and load queues per cycle and registers
// the winner as the register file's write request
`timescale 1ns/1ps

module wb_arbiter (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   alu_empty,
   input  wb_pkg::alu_wb_t        alu_head,
   output logic                   alu_pop,
   input  logic                   lsu_empty,
   input  wb_pkg::lsu_wb_t        lsu_head,
   output logic                   lsu_pop,
   output logic                   wr_valid,
   output regfile_pkg::rf_write_t wr
);

   logic                   last_alu; // ALU won the last grant
   regfile_pkg::rf_write_t wr_nxt;

   // ALU goes when alone, or when it is its turn
   assign alu_pop = !alu_empty && (lsu_empty || !last_alu);
   assign lsu_pop = !lsu_empty && !alu_pop;

   // common write format
   always_comb
   begin
      if (alu_pop)
      begin
         wr_nxt.addr    = alu_head.addr;
         wr_nxt.data    = alu_head.data;
         wr_nxt.byte_en = '1;             // full word
      end
      else
      begin
         wr_nxt.addr    = lsu_head.addr;
         wr_nxt.data    = lsu_head.data;
         wr_nxt.byte_en = lsu_head.byte_en;
      end
   end

   // grant state
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_valid <= 1'b0;
         last_alu <= 1'b0;                // ALU first after reset
      end
      else
      begin
         wr_valid <= alu_pop || lsu_pop;
         if (alu_pop)
            last_alu <= 1'b1;
         else if (lsu_pop)
            last_alu <= 1'b0;
      end
   end

   // request payload, only meaningful with wr_valid
   always_ff @(posedge clk)
   begin
      if (alu_pop || lsu_pop)
         wr <= wr_nxt;
   end

endmodule

//--- verilog/reg_file_subsystem.sv
// vector register file subsystem
// ALU and load unit writebacks are queued, merged by a round-robin
// arbiter onto one write port, three read ports go straight through
`timescale 1ns/1ps

module reg_file_subsystem (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  alu_push,
   input  wb_pkg::alu_wb_t       alu_req,
   output logic                  alu_full,
   input  logic                  lsu_push,
   input  wb_pkg::lsu_wb_t       lsu_req,
   output logic                  lsu_full,
   input  regfile_pkg::rf_addr_t rd_addr [regfile_pkg::rf_read_ports],
   output regfile_pkg::rf_data_t rd_data [regfile_pkg::rf_read_ports],
   output logic                  wb_idle
);

   wb_pkg::alu_wb_t        alu_head;
   wb_pkg::lsu_wb_t        lsu_head;
   logic                   alu_empty;
   logic                   lsu_empty;
   logic                   alu_pop;
   logic                   lsu_pop;
   logic                   wr_valid;
   regfile_pkg::rf_write_t wr;

   // nothing queued and nothing in flight
   assign wb_idle = alu_empty && lsu_empty && !wr_valid;

   wb_queue #(.payload_t(wb_pkg::alu_wb_t)) alu_queue_inst (
      .clk       (clk),
      .rst       (rst),
      .push      (alu_push),
      .push_data (alu_req),
      .pop       (alu_pop),
      .head      (alu_head),
      .empty     (alu_empty),
      .full      (alu_full)
   );

   wb_queue #(.payload_t(wb_pkg::lsu_wb_t)) lsu_queue_inst (
      .clk       (clk),
      .rst       (rst),
      .push      (lsu_push),
      .push_data (lsu_req),
      .pop       (lsu_pop),
      .head      (lsu_head),
      .empty     (lsu_empty),
      .full      (lsu_full)
   );

   wb_arbiter wb_arbiter_inst (
      .clk       (clk),
      .rst       (rst),
      .alu_empty (alu_empty),
      .alu_head  (alu_head),
      .alu_pop   (alu_pop),
      .lsu_empty (lsu_empty),
      .lsu_head  (lsu_head),
      .lsu_pop   (lsu_pop),
      .wr_valid  (wr_valid),
      .wr        (wr)
   );

   reg_file_1024x32_3r_1w reg_file_inst (
      .clk      (clk),
      .rst      (rst),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .wr_valid (wr_valid),
      .wr       (wr)
   );

endmodule

//--- testbench/reg_file_checker.sv
// register file subsystem checker
// mirrors every accepted writeback into a model array and compares
// read data one cycle after each sampled address
`timescale 1ns/1ps

module reg_file_checker (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  alu_push,
   input  wb_pkg::alu_wb_t       alu_req,
   input  logic                  alu_full,
   input  logic                  lsu_push,
   input  wb_pkg::lsu_wb_t       lsu_req,
   input  logic                  lsu_full,
   input  regfile_pkg::rf_addr_t rd_addr [regfile_pkg::rf_read_ports],
   input  regfile_pkg::rf_data_t rd_data [regfile_pkg::rf_read_ports],
   input  logic                  wb_idle,
   input  logic                  rd_check,    // read addresses this cycle are to be checked
   input  logic                  state_check, // compare the reset state of the flags
   input  logic                  test_end,
   input  int                    test_id,
   output int                    error_count,
   output int                    check_count,
   output int                    test_count,
   output int                    fail_count
);

   regfile_pkg::rf_data_t model    [regfile_pkg::rf_depth];
   regfile_pkg::rf_data_t exp_data [regfile_pkg::rf_read_ports]; // expected word per port
   regfile_pkg::rf_addr_t exp_addr [regfile_pkg::rf_read_ports];
   logic rd_pending   = 1'b0; // a read is one cycle old
   logic saw_alu_full = 1'b0;
   logic saw_lsu_full = 1'b0;
   int   errors = 0;
   int   checks = 0;
   int   tests = 0;
   int   fails = 0;
   int   errors_before = 0; // totals at the start of the running test
   int   checks_before = 0;

   assign error_count = errors;
   assign check_count = checks;
   assign test_count  = tests;
   assign fail_count  = fails;

   function automatic string test_name(input int id);
      case (id)
         1:       return "reset state";
         2:       return "alu full-word writes";
         3:       return "load byte merge";
         4:       return "interleaved sources";
         5:       return "back-pressure";
         6:       return "shared and bank-aliased reads";
         default: return "setup";
      endcase
   endfunction

   task automatic compare(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("ERROR %s: %s expected %h actual %h", test_name(test_id), what,
                  expected, actual);
      end
   endtask

   always @(posedge clk)
   begin
      // data for last cycle's addresses is on the ports now
      if (rd_pending)
      begin
         for (int p = 0; p < regfile_pkg::rf_read_ports; p++)
            compare($sformatf("rd_data[%0d] addr %h", p, exp_addr[p]), exp_data[p], rd_data[p]);
      end
      rd_pending = rd_check && !rst;
      if (rd_check)
      begin
         for (int p = 0; p < regfile_pkg::rf_read_ports; p++)
         begin
            exp_addr[p] = rd_addr[p];
            exp_data[p] = model[rd_addr[p]]; // taken before this edge's pushes
         end
      end
      if (state_check)
      begin
         compare("alu_full", 32'd0, {31'd0, alu_full});
         compare("lsu_full", 32'd0, {31'd0, lsu_full});
         compare("wb_idle", 32'd1, {31'd0, wb_idle});
      end
      // a push counts only when the queue was not full
      if (!rst && alu_push && !alu_full)
         model[alu_req.addr] = alu_req.data;
      if (!rst && lsu_push && !lsu_full)
      begin
         for (int i = 0; i < $bits(regfile_pkg::rf_byte_en_t); i++)
         begin
            if (lsu_req.byte_en[i])
               model[lsu_req.addr][8*i +: 8] = lsu_req.data[8*i +: 8]; // other lanes hold
         end
      end
      saw_alu_full = saw_alu_full || alu_full;
      saw_lsu_full = saw_lsu_full || lsu_full;
      if (test_end)
      begin
         if (test_id == 5 && !(saw_alu_full && saw_lsu_full))
         begin
            errors++;
            $display("back-pressure test: a writeback queue never reported full");
         end
         tests++;
         if (errors != errors_before)
            fails++;
         $display("test %0d %s: %0d checks, %0d errors", test_id, test_name(test_id),
                  checks - checks_before, errors - errors_before);
         errors_before = errors;
         checks_before = checks;
         saw_alu_full  = 1'b0;
         saw_lsu_full  = 1'b0;
      end
   end

endmodule

//--- testbench/tb_reg_file_subsystem.sv
// testbench for the register file subsystem
// fills the file, then runs LCG driven writeback bursts from both sources
// and reads everything back on all three ports
`timescale 1ns/1ps

module tb_reg_file_subsystem;

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  alu_push;
   wb_pkg::alu_wb_t       alu_req;
   logic                  alu_full;
   logic                  lsu_push;
   wb_pkg::lsu_wb_t       lsu_req;
   logic                  lsu_full;
   regfile_pkg::rf_addr_t rd_addr [regfile_pkg::rf_read_ports];
   regfile_pkg::rf_data_t rd_data [regfile_pkg::rf_read_ports];
   logic                  wb_idle;
   logic                  rd_check;
   logic                  state_check;
   logic                  test_end;
   int                    test_id;
   int                    error_count;
   int                    check_count;
   int                    test_count;
   int                    fail_count;
   logic [31:0]           rng = 32'hd18e;  // LCG state
   wb_pkg::alu_wb_t       alu_q [$];       // requests not yet accepted
   wb_pkg::lsu_wb_t       lsu_q [$];
   regfile_pkg::rf_addr_t touched [$];     // addresses to read back

   always #4 clk = ~clk;

   reg_file_subsystem reg_file_subsystem_inst (
      .clk(clk), .rst(rst),
      .alu_push(alu_push), .alu_req(alu_req), .alu_full(alu_full),
      .lsu_push(lsu_push), .lsu_req(lsu_req), .lsu_full(lsu_full),
      .rd_addr(rd_addr), .rd_data(rd_data), .wb_idle(wb_idle)
   );

   reg_file_checker checker_inst (
      .clk(clk), .rst(rst),
      .alu_push(alu_push), .alu_req(alu_req), .alu_full(alu_full),
      .lsu_push(lsu_push), .lsu_req(lsu_req), .lsu_full(lsu_full),
      .rd_addr(rd_addr), .rd_data(rd_data), .wb_idle(wb_idle),
      .rd_check(rd_check), .state_check(state_check), .test_end(test_end),
      .test_id(test_id), .error_count(error_count), .check_count(check_count),
      .test_count(test_count), .fail_count(fail_count)
   );

   function automatic logic [31:0] next_rand();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng ^ (rng >> 15); // fold the better high bits down
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $finish;
   endtask

   task automatic add_alu(input regfile_pkg::rf_addr_t a, input regfile_pkg::rf_data_t d);
      wb_pkg::alu_wb_t r;
      r.addr = a;
      r.data = d;
      alu_q.push_back(r);
      touched.push_back(a);
   endtask

   task automatic add_lsu(input regfile_pkg::rf_addr_t a, input regfile_pkg::rf_data_t d,
                          input regfile_pkg::rf_byte_en_t be);
      wb_pkg::lsu_wb_t r;
      r.addr    = a;
      r.data    = d;
      r.byte_en = be;
      lsu_q.push_back(r);
      touched.push_back(a);
   endtask

   // ALU on even and load unit on odd addresses, so a burst never collides
   task automatic queue_both(input int count, input bit hot);
      logic [31:0]           r;
      regfile_pkg::rf_addr_t alu_hot;
      regfile_pkg::rf_addr_t lsu_hot;
      r       = next_rand();
      alu_hot = {r[9:1], 1'b0};
      lsu_hot = {r[19:11], 1'b1};
      for (int k = 0; k < count; k++)
      begin
         r = next_rand();
         if (hot && k % 4 == 0)
            add_alu(alu_hot, next_rand()); // repeated target, last one wins
         else
            add_alu({r[9:1], 1'b0}, next_rand());
         r = next_rand();
         if (hot && k % 4 == 2)
            add_lsu(lsu_hot, next_rand(), r[27:24]);
         else
            add_lsu({r[9:1], 1'b1}, next_rand(), r[27:24]);
      end
   endtask

   // feed both queues, hold a request until it is taken, back off while full
   task automatic run_pushes();
      int cycles;
      cycles = 0;
      while (alu_q.size() > 0 || lsu_q.size() > 0 || alu_push || lsu_push)
      begin
         @(posedge clk);
         if (alu_push && !alu_full)
            alu_q.delete(0);
         if (lsu_push && !lsu_full)
            lsu_q.delete(0);
         alu_push <= (alu_q.size() > 0) && !alu_full;
         lsu_push <= (lsu_q.size() > 0) && !lsu_full;
         if (alu_q.size() > 0)
            alu_req <= alu_q[0];
         if (lsu_q.size() > 0)
            lsu_req <= lsu_q[0];
         cycles++;
         if (cycles > 5000)
            abort_run("timeout: writeback requests were not accepted");
      end
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      @(posedge clk);
      while (!wb_idle)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > 200)
            abort_run("timeout: writeback path never went idle");
      end
   endtask

   task automatic read_three(input regfile_pkg::rf_addr_t a0, input regfile_pkg::rf_addr_t a1,
                             input regfile_pkg::rf_addr_t a2);
      @(posedge clk);
      rd_addr[0] <= a0;
      rd_addr[1] <= a1;
      rd_addr[2] <= a2;
      rd_check   <= 1'b1;
   endtask

   // each port gets a different touched address
   task automatic read_back();
      int n;
      n = touched.size();
      for (int i = 0; i < n; i++)
         read_three(touched[i], touched[(i + 1) % n], touched[(i + 2) % n]);
      touched.delete();
   endtask

   task automatic close_test();
      @(posedge clk);
      rd_check <= 1'b0;
      @(posedge clk);
      test_end <= 1'b1;  // last read compared by now
      @(posedge clk);
      test_end <= 1'b0;
   endtask

   task automatic write_test(input int id);
      test_id <= id;
      run_pushes();
      wait_idle();
      read_back();
      close_test();
   endtask

   initial
   begin
      logic [31:0] r;
      rst         = 1'b1;
      alu_push    = 1'b0;
      alu_req     = '0;
      lsu_push    = 1'b0;
      lsu_req     = '0;
      rd_check    = 1'b0;
      state_check = 1'b0;
      test_end    = 1'b0;
      test_id     = 0;
      for (int p = 0; p < regfile_pkg::rf_read_ports; p++)
         rd_addr[p] = '0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      test_id <= 1;
      @(posedge clk);
      state_check <= 1'b1;
      @(posedge clk);
      state_check <= 1'b0;
      close_test();

      // known contents everywhere, the odd multiplier keeps words distinct
      test_id <= 0;
      for (int a = 0; a < regfile_pkg::rf_depth; a++)
         add_alu(regfile_pkg::rf_addr_t'(a), 32'h9e3779b9 * (32'(a) + 32'd1));
      run_pushes();
      wait_idle();
      touched.delete();

      for (int k = 0; k < 48; k++)
      begin
         r = next_rand();
         add_alu({k[1:0], r[7:0]}, next_rand()); // bank walks with k
      end
      write_test(2);

      for (int k = 0; k < 48; k++)
      begin
         r = next_rand();
         add_lsu(r[9:0], next_rand(), r[23:20]);
      end
      write_test(3);

      queue_both(32, 1'b1);
      write_test(4);

      queue_both(64, 1'b0);
      write_test(5);

      test_id <= 6;
      for (int k = 0; k < 16; k++)
      begin
         r = next_rand();
         read_three(r[17:8], r[17:8], r[17:8]);
         read_three({2'd0, r[7:0]}, {2'd1, r[7:0]}, {2'd2, r[7:0]});
         read_three({2'd3, r[7:0]}, {2'd0, r[7:0]}, {2'd1, r[7:0]});
      end
      close_test();

      repeat (2) @(posedge clk);
      $display("tests %0d, failed %0d, checks %0d, errors %0d", test_count, fail_count,
               check_count, error_count);
      if (error_count == 0 && fail_count == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- project.f
verilog/regfile_pkg.sv
verilog/wb_pkg.sv
verilog/reg_bank_256x32_3r_1w.sv
verilog/reg_file_1024x32_3r_1w.sv
verilog/wb_queue.sv
verilog/wb_arbiter.sv
verilog/reg_file_subsystem.sv
testbench/reg_file_checker.sv
testbench/tb_reg_file_subsystem.sv

//--- Makefile
TOP := tb_reg_file_subsystem

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f verilog/*.sv testbench/*.sv
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only -Wall verilog/regfile_pkg.sv verilog/wb_pkg.sv \
		verilog/reg_bank_256x32_3r_1w.sv verilog/reg_file_1024x32_3r_1w.sv \
		verilog/wb_queue.sv verilog/wb_arbiter.sv verilog/reg_file_subsystem.sv \
		--top-module reg_file_subsystem

clean:
	rm -rf obj_dir
